//--- include/mul_macros.svh
`ifndef MUL_MACROS_SVH
`define MUL_MACROS_SVH

// ============================================================
// op codes from the decode stage.
// ============================================================

// low word of the product.
`define MUL_OP_MUL    8'h1c
// high word of the signed product.
`define MUL_OP_MULH   8'h1d
// high word of the unsigned product.
`define MUL_OP_MULHU  8'h1e

// ============================================================
// pipeline shape.
// ============================================================

// 1, 2, 4 or 8 partial-product stages.
`define MUL_STAGES      4
`define MUL_STAGE_BITS  (32 / `MUL_STAGES)

// issue slot, one cycle per stage, result register.
`define MUL_LATENCY     (`MUL_STAGES + 2)

`endif

//--- hdl/mul_pkg.sv
`default_nettype none

package mul_pkg;

    // ============================================================
    // widths shared by the multiply pipeline.
    // ============================================================

    // op code as presented by decode.
    typedef logic [7:0] op_t;

    // operand and result word.
    typedef logic [31:0] word_t;

    // extended multiplicand and running product.
    typedef logic [63:0] dword_t;

endpackage

`default_nettype wire

//--- hdl/mul_issue.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_macros.svh"

module mul_issue (
    input  logic            clk,
    input  logic            rst_n,
    input  mul_pkg::op_t    op,
    input  mul_pkg::word_t  mul_in_a,
    input  mul_pkg::word_t  mul_in_b,
    output logic            valid,
    output mul_pkg::dword_t a_ext,
    output mul_pkg::word_t  b,
    output logic            is_signed,
    output logic            sel_hi
);

    logic is_mul;
    logic is_sgn;
    logic is_hi;

    // decode the op code once, the stages only see control bits.
    always_comb begin
        is_mul = (op == `MUL_OP_MUL) || (op == `MUL_OP_MULH) || (op == `MUL_OP_MULHU);
        is_sgn = (op == `MUL_OP_MUL) || (op == `MUL_OP_MULH);
        is_hi  = (op == `MUL_OP_MULH) || (op == `MUL_OP_MULHU);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else begin
            valid <= is_mul;
        end
    end

    // slot 0 payload.
    always_ff @(posedge clk) begin
        if (is_sgn) begin
            a_ext <= {{32{mul_in_a[31]}}, mul_in_a};
        end else begin
            a_ext <= {32'b0, mul_in_a};
        end
        b         <= mul_in_b;
        is_signed <= is_sgn;
        sel_hi    <= is_hi;
    end

endmodule

`default_nettype wire

//--- hdl/mul_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_macros.svh"

module mul_stage #(
    parameter int STAGE_IDX = 0
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid_in,
    input  mul_pkg::dword_t a_ext_in,
    input  mul_pkg::word_t  b_in,
    input  logic            is_signed_in,
    input  logic            sel_hi_in,
    input  mul_pkg::dword_t acc_in,
    output logic            valid_out,
    output mul_pkg::dword_t a_ext_out,
    output mul_pkg::word_t  b_out,
    output logic            is_signed_out,
    output logic            sel_hi_out,
    output mul_pkg::dword_t acc_out
);

    // lowest multiplier bit owned by this stage.
    localparam int LO_BIT = STAGE_IDX * `MUL_STAGE_BITS;

    // the last stage holds bit 31, which weighs -2^31 for signed ops.
    localparam bit OWNS_MSB = (LO_BIT + `MUL_STAGE_BITS - 1) == 31;

    mul_pkg::dword_t sum;

    always_comb begin
        sum = acc_in;
        for (int j = 0; j < `MUL_STAGE_BITS; j++) begin
            if (b_in[LO_BIT + j]) begin
                if (OWNS_MSB && (j == `MUL_STAGE_BITS - 1) && is_signed_in) begin
                    sum = sum - (a_ext_in << (LO_BIT + j));
                end else begin
                    sum = sum + (a_ext_in << (LO_BIT + j));
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        a_ext_out     <= a_ext_in;
        b_out         <= b_in;
        is_signed_out <= is_signed_in;
        sel_hi_out    <= sel_hi_in;
        acc_out       <= sum;
    end

endmodule

`default_nettype wire

//--- hdl/mul_result.sv
`timescale 1ns/10ps
`default_nettype none

module mul_result (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            valid,
    input  logic            sel_hi,
    input  mul_pkg::dword_t acc,
    output logic            mul_out_valid,
    output mul_pkg::word_t  mul_out
);

    mul_pkg::word_t word_sel;

    // MULH and MULHU take the upper half.
    always_comb begin
        if (sel_hi) begin
            word_sel = acc[63:32];
        end else begin
            word_sel = acc[31:0];
        end
    end

    // ============================================================
    // output register, holds the last result between pulses.
    // ============================================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mul_out_valid <= 1'b0;
            mul_out       <= '0;
        end else begin
            mul_out_valid <= valid;
            if (valid) begin
                mul_out <= word_sel;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/mul_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_macros.svh"

module mul_unit (
    input  logic           clk,
    input  logic           rst_n,
    input  mul_pkg::op_t   op,
    input  mul_pkg::word_t mul_in_a,
    input  mul_pkg::word_t mul_in_b,
    output logic           mul_out_valid,
    output mul_pkg::word_t mul_out
);

    // slot k feeds stage k, slot MUL_STAGES feeds the result block.
    logic [`MUL_STAGES:0] valid_s;
    logic [`MUL_STAGES:0] is_signed_s;
    logic [`MUL_STAGES:0] sel_hi_s;
    mul_pkg::dword_t      a_ext_s [`MUL_STAGES+1];
    mul_pkg::word_t       b_s     [`MUL_STAGES+1];
    mul_pkg::dword_t      acc_s   [`MUL_STAGES+1];

    // running product starts empty.
    assign acc_s[0] = '0;

    mul_issue issue_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .mul_in_a  (mul_in_a),
        .mul_in_b  (mul_in_b),
        .valid     (valid_s[0]),
        .a_ext     (a_ext_s[0]),
        .b         (b_s[0]),
        .is_signed (is_signed_s[0]),
        .sel_hi    (sel_hi_s[0])
    );

    // ============================================================
    // partial-product chain.
    // ============================================================

    for (genvar k = 0; k < `MUL_STAGES; k++) begin : g_stage
        mul_stage #(
            .STAGE_IDX (k)
        ) stage_i (
            .clk           (clk),
            .rst_n         (rst_n),
            .valid_in      (valid_s[k]),
            .a_ext_in      (a_ext_s[k]),
            .b_in          (b_s[k]),
            .is_signed_in  (is_signed_s[k]),
            .sel_hi_in     (sel_hi_s[k]),
            .acc_in        (acc_s[k]),
            .valid_out     (valid_s[k+1]),
            .a_ext_out     (a_ext_s[k+1]),
            .b_out         (b_s[k+1]),
            .is_signed_out (is_signed_s[k+1]),
            .sel_hi_out    (sel_hi_s[k+1]),
            .acc_out       (acc_s[k+1])
        );
    end

    mul_result result_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid         (valid_s[`MUL_STAGES]),
        .sel_hi        (sel_hi_s[`MUL_STAGES]),
        .acc           (acc_s[`MUL_STAGES]),
        .mul_out_valid (mul_out_valid),
        .mul_out       (mul_out)
    );

endmodule

`default_nettype wire

//--- dv/mul_unit_sva.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_macros.svh"

module mul_unit_sva (
    input logic           clk,
    input logic           rst_n,
    input mul_pkg::op_t   op,
    input logic           mul_out_valid,
    input mul_pkg::word_t mul_out
);

    logic op_is_mul;

    assign op_is_mul = (op == `MUL_OP_MUL) || (op == `MUL_OP_MULH) || (op == `MUL_OP_MULHU);

    // ============================================================
    // reset and strobe timing.
    // ============================================================

    // synchronous reset, so the strobe is low from the edge after.
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !mul_out_valid)
        else $error("mul_out_valid high after a reset cycle");

    issue_gives_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        op_is_mul |-> ##(`MUL_LATENCY) mul_out_valid)
        else $error("no result pulse at the fixed latency after a multiply op");

    pulse_has_issue: assert property (@(posedge clk) disable iff (!rst_n)
        mul_out_valid |-> $past(op_is_mul, `MUL_LATENCY))
        else $error("result pulse without a multiply op at the fixed latency before");

    result_known: assert property (@(posedge clk) mul_out_valid |-> !$isunknown(mul_out))
        else $error("mul_out unknown during a result pulse");

endmodule

bind mul_unit mul_unit_sva sva_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .op            (op),
    .mul_out_valid (mul_out_valid),
    .mul_out       (mul_out)
);

`default_nettype wire

//--- dv/mul_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "mul_macros.svh"

module mul_unit_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 10;
    localparam int IDLE_CYCLES  = 8;
    localparam int RAND_CYCLES  = 200;
    localparam int DRAIN_LIMIT  = `MUL_LATENCY + 4;
    // reset, idle runs, 75 corner ops, random ops, one held op and six drains.
    localparam int TEST_CYCLES  = RESET_CYCLES + 2 * IDLE_CYCLES + 75 + RAND_CYCLES + 1
                                  + 6 * DRAIN_LIMIT;
    localparam int WATCHDOG_CYCLES = TEST_CYCLES + `MUL_LATENCY + 50;

    logic           clk;
    logic           rst_n;
    mul_pkg::op_t   op;
    mul_pkg::word_t mul_in_a;
    mul_pkg::word_t mul_in_b;
    logic           mul_out_valid;
    mul_pkg::word_t mul_out;

    int     cyc = 0;
    int     checks = 0;
    int     errors = 0;
    int     checks_at_start;
    int     errors_at_start;
    int     tests_run = 0;
    integer seed;

    // outstanding operations, oldest first.
    mul_pkg::word_t exp_q  [$];
    string          name_q [$];
    int             cyc_q  [$];

    mul_pkg::word_t corners [5];

    mul_unit dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .op            (op),
        .mul_in_a      (mul_in_a),
        .mul_in_b      (mul_in_b),
        .mul_out_valid (mul_out_valid),
        .mul_out       (mul_out)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ============================================================
    // reference model.
    // ============================================================

    function automatic logic is_mul_op(input mul_pkg::op_t code);
        return (code == `MUL_OP_MUL) || (code == `MUL_OP_MULH) || (code == `MUL_OP_MULHU);
    endfunction

    function automatic mul_pkg::word_t ref_mul(input mul_pkg::op_t code,
                                               input mul_pkg::word_t a,
                                               input mul_pkg::word_t b);
        longint          sa;
        longint          sb;
        longint unsigned ua;
        longint unsigned ub;
        logic [63:0]     prod;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        if (code == `MUL_OP_MULHU) begin
            prod = ua * ub;
        end else begin
            prod = sa * sb;
        end
        if (code == `MUL_OP_MUL) begin
            return prod[31:0];
        end else begin
            return prod[63:32];
        end
    endfunction

    // ============================================================
    // stimulus and bookkeeping.
    // ============================================================

    task automatic drive_op(input mul_pkg::op_t code, input mul_pkg::word_t a,
                            input mul_pkg::word_t b, input string test);
        @(posedge clk);
        #1;
        op       = code;
        mul_in_a = a;
        mul_in_b = b;
        if (is_mul_op(code)) begin
            exp_q.push_back(ref_mul(code, a, b));
            name_q.push_back($sformatf("%s %08h*%08h", test, a, b));
            cyc_q.push_back(cyc);
        end
    endtask

    task automatic drain_results();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            drive_op(8'h00, '0, '0, "idle");
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("missing results: %0d operations never returned a valid pulse",
                     exp_q.size());
            errors = errors + exp_q.size();
            exp_q.delete();
            name_q.delete();
            cyc_q.delete();
        end
    endtask

    task automatic begin_test();
        checks_at_start = checks;
        errors_at_start = errors;
    endtask

    task automatic end_test(input string test);
        drain_results();
        tests_run++;
        $display("test %s: %0d checks, %0d errors", test,
                 checks - checks_at_start, errors - errors_at_start);
    endtask

    // each pulse retires the oldest outstanding operation.
    always @(negedge clk) begin : compare_results
        mul_pkg::word_t exp_val;
        string          name;
        int             issue_cyc;
        if (mul_out_valid) begin
            if (exp_q.size() == 0) begin
                $display("unexpected valid pulse at cycle %0d with no operation outstanding",
                         cyc);
                errors++;
            end else begin
                exp_val   = exp_q.pop_front();
                name      = name_q.pop_front();
                issue_cyc = cyc_q.pop_front();
                checks++;
                if (mul_out !== exp_val) begin
                    $display("ERR %s: expected %08h, actual %08h", name, exp_val, mul_out);
                    errors++;
                end
                if (cyc - issue_cyc != `MUL_LATENCY) begin
                    $display("ERR %s latency: expected %0d, actual %0d", name,
                             `MUL_LATENCY, cyc - issue_cyc);
                    errors++;
                end
            end
        end
    end

    // ============================================================
    // tests.
    // ============================================================

    task automatic check_reset_state();
        begin_test();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // op codes from 0x1f upward are not multiplies.
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            drive_op(8'h1f + 8'(i), 32'h0000_0003, 32'h0000_0005, "reset");
        end
        @(negedge clk);
        checks = checks + 2;
        if (mul_out_valid !== 1'b0) begin
            $display("valid pulse seen after reset while only non-multiply ops were driven");
            errors++;
        end
        if (mul_out !== 32'h0) begin
            $display("ERR reset mul_out: expected %08h, actual %08h", 32'h0, mul_out);
            errors++;
        end
        end_test("reset");
    endtask

    task automatic sweep_corner_pairs(input mul_pkg::op_t code, input string test);
        begin_test();
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                drive_op(code, corners[i], corners[j], test);
            end
        end
        end_test(test);
    endtask

    task automatic stream_random_ops();
        int             sel;
        mul_pkg::op_t   code;
        mul_pkg::word_t a;
        mul_pkg::word_t b;
        begin_test();
        for (int i = 0; i < RAND_CYCLES; i++) begin
            sel = $random(seed) & 7;
            a   = $random(seed);
            b   = $random(seed);
            case (sel)
                0, 1: code = `MUL_OP_MUL;
                2, 3: code = `MUL_OP_MULH;
                4, 5: code = `MUL_OP_MULHU;
                default: begin
                    code = 8'($random(seed));
                    if (is_mul_op(code)) begin
                        code = 8'h00;
                    end
                end
            endcase
            drive_op(code, a, b, "random");
        end
        end_test("random");
    endtask

    task automatic hold_last_result();
        mul_pkg::word_t held;
        begin_test();
        held = ref_mul(`MUL_OP_MUL, 32'h1234_5678, 32'h0000_0009);
        drive_op(`MUL_OP_MUL, 32'h1234_5678, 32'h0000_0009, "holding");
        drain_results();
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            drive_op(8'h00, '0, '0, "holding");
            @(negedge clk);
            checks++;
            if (mul_out !== held) begin
                $display("ERR holding: expected %08h, actual %08h", held, mul_out);
                errors++;
            end
            if (mul_out_valid !== 1'b0) begin
                $display("valid pulse seen during idle cycles after the held result");
                errors++;
            end
        end
        end_test("holding");
    endtask

    initial begin
        rst_n    = 1'b0;
        op       = '0;
        mul_in_a = '0;
        mul_in_b = '0;
        seed     = 32'hd0e85259;
        corners[0] = 32'h0000_0000;
        corners[1] = 32'h0000_0001;
        corners[2] = 32'hffff_ffff;
        corners[3] = 32'h8000_0000;
        corners[4] = 32'h7fff_ffff;

        check_reset_state();
        sweep_corner_pairs(`MUL_OP_MUL, "mul_corners");
        sweep_corner_pairs(`MUL_OP_MULH, "mulh_corners");
        sweep_corner_pairs(`MUL_OP_MULHU, "mulhu_corners");
        stream_random_ops();
        hold_last_result();

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/mul_pkg.sv
hdl/mul_issue.sv
hdl/mul_stage.sv
hdl/mul_result.sv
hdl/mul_unit.sv
dv/mul_unit_sva.sv
dv/mul_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mul_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module mul_unit_tb -f verilog.f \
    -Mdir "$build_dir" -o mul_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/mul_unit_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$log_file"; then
    exit 0
else
    echo "pass line not found in $log_file"
    exit 1
fi
